/* design/sensor_pkg.sv */
// sensor_pkg: address map, widths and packed types shared by the sensor control blocks
package sensor_pkg;

    localparam int NUM_SENSORS = 4;                      // sensor channels
    localparam int CHN_BITS    = $clog2(NUM_SENSORS);    // channel index width

    // command address map, channel 0 at group base
    localparam logic [15:0] SENSOR_GROUP_ADDR    = 16'h0400; // channel 0 registers
    localparam logic [15:0] SENSOR_BASE_INC      = 16'h0040; // step per channel
    localparam logic [15:0] SENS_SYNC_STATUS_REL = 16'h0005; // status request, data[5:0] = seq
    localparam logic [15:0] SENS_SYNC_LATE_REL   = 16'h0007; // late sof delay in lines

    // frame sync
    localparam int SENS_SYNC_LBITS     = 16;  // line counter width
    localparam int SENS_SYNC_LATE_DFLT = 15;  // lines of delay out of reset
    localparam int FRAME_BITS          = 18;  // frame counter, wraps

    // status address map
    localparam logic [7:0] STATUS_REG_BASE = 8'h20; // channel 0 status address
    localparam logic [7:0] STATUS_REG_INC  = 8'h02; // step per channel

    // byte-serial framing
    localparam int CMD_BYTES    = 6;  // AL AH D0 D1 D2 D3
    localparam int STATUS_BYTES = 4;  // addr st0 st1 st2
    localparam int SEQ_BITS     = 6;  // sequence number in st0

    // one register write from the command port
    typedef struct packed {
        logic [15:0] addr;  // register address
        logic [31:0] data;  // register data
    } cmd_t;

    // sensor timing pulses of one channel, all on mclk
    typedef struct packed {
        logic sof;       // start of frame
        logic eof;       // end of frame
        logic line_end;  // end of a line
    } sync_in_t;

    // status packet, addr goes out first
    typedef struct packed {
        logic [7:0] addr;  // status register address
        logic [7:0] st0;   // {seq, frame[1:0]}
        logic [7:0] st1;   // frame[9:2]
        logic [7:0] st2;   // frame[17:10]
    } status_pkt_t;

endpackage

/* design/cmd_deser.sv */
// cmd_deser: assembles the six byte-serial command bytes into one register write pulse
`timescale 1ns/1ps

module cmd_deser (
    input  logic             mclk,
    input  logic             rst,
    input  logic [7:0]       cmd_ad,     // AL AH D0 D1 D2 D3, one per cycle
    input  logic             cmd_stb,    // high with AL
    output sensor_pkg::cmd_t cmd,        // valid while cmd_valid
    output logic             cmd_valid   // single cycle write pulse
);
    import sensor_pkg::*;

    logic [CMD_BYTES*8-1:0]       shift_r;  // newest byte enters at the top
    logic [$clog2(CMD_BYTES)-1:0] byte_cnt; // bytes taken so far
    logic                         busy;     // collecting AH..D3

    // byte position and write pulse
    always_ff @(posedge mclk) begin
        if (rst) begin
            busy      <= 1'b0;
            byte_cnt  <= '0;
            cmd_valid <= 1'b0;
        end else begin
            cmd_valid <= 1'b0;
            if (cmd_stb) begin                  // AL, also restarts a partial command
                busy     <= 1'b1;
                byte_cnt <= 1;
            end else if (busy) begin
                byte_cnt <= byte_cnt + 1'b1;
                if (byte_cnt == ($clog2(CMD_BYTES))'(CMD_BYTES - 1)) begin
                    busy      <= 1'b0;          // D3 taken
                    byte_cnt  <= '0;
                    cmd_valid <= 1'b1;
                end
            end
        end
    end

    // shift right so AL ends in the low byte
    always_ff @(posedge mclk) begin
        if (cmd_stb || busy) begin
            shift_r <= {cmd_ad, shift_r[CMD_BYTES*8-1:8]};
        end
    end

    // little-endian fields, stable during the valid cycle
    assign cmd.addr = shift_r[15:0];             // {AH, AL}
    assign cmd.data = shift_r[CMD_BYTES*8-1:16]; // {D3, D2, D1, D0}

endmodule

/* design/late_line_timer.sv */
// late_line_timer: delays start of frame by a programmed number of lines, cut short by eof
`timescale 1ns/1ps

module late_line_timer (
    input  logic                                mclk,
    input  logic                                rst,
    input  sensor_pkg::sync_in_t                sync,     // sof, eof, line_end
    input  logic [sensor_pkg::SENS_SYNC_LBITS-1:0] late,  // lines to wait, 0 = at once
    output logic                                sof_late  // one cycle pulse
);
    import sensor_pkg::*;

    logic                       pending;    // sof seen, late pulse not yet sent
    logic [SENS_SYNC_LBITS-1:0] line_cnt;   // line_end pulses since sof
    logic [SENS_SYNC_LBITS-1:0] line_next;  // count including this line_end
    logic                       lines_done; // this line_end reaches the delay

    assign line_next  = line_cnt + 1'b1;
    assign lines_done = sync.line_end && (line_next == late);

    always_ff @(posedge mclk) begin
        if (rst) begin
            pending  <= 1'b0;
            line_cnt <= '0;
            sof_late <= 1'b0;
        end else begin
            sof_late <= 1'b0;
            if (sync.sof) begin
                // new frame restarts the count
                line_cnt <= '0;
                if (late == '0) begin
                    sof_late <= 1'b1;       // zero delay, follow sof
                    pending  <= 1'b0;
                end else begin
                    pending  <= 1'b1;
                end
            end else if (pending) begin
                if (sync.eof || lines_done) begin
                    sof_late <= 1'b1;       // early eof or delay reached
                    pending  <= 1'b0;
                end else if (sync.line_end) begin
                    line_cnt <= line_next;
                end
            end
        end
    end

endmodule

/* design/sync_chn.sv */
// sync_chn: per-channel register decode, frame counter, late sof and status packet request
`timescale 1ns/1ps

module sync_chn #(
    parameter int chn = 0  // channel index, below NUM_SENSORS
) (
    input  logic                    mclk,
    input  logic                    rst,
    input  sensor_pkg::cmd_t        cmd,         // shared register write
    input  logic                    cmd_valid,
    input  sensor_pkg::sync_in_t    sync,        // this channel's sensor pulses
    output logic                    sof_late,
    output sensor_pkg::status_pkt_t status_pkt,  // held while status_rq
    output logic                    status_rq,
    input  logic                    start        // router took the packet
);
    import sensor_pkg::*;

    // this channel's register and status addresses
    localparam logic [15:0] chn_base    = 16'(SENSOR_GROUP_ADDR + chn * SENSOR_BASE_INC);
    localparam logic [15:0] late_addr   = chn_base + SENS_SYNC_LATE_REL;
    localparam logic [15:0] status_addr = chn_base + SENS_SYNC_STATUS_REL;
    localparam logic [7:0]  status_reg  = 8'(STATUS_REG_BASE + STATUS_REG_INC * chn);

    logic                       wr_late;    // write to the late register
    logic                       wr_status;  // status packet request
    logic [SENS_SYNC_LBITS-1:0] late;       // lines of delay
    logic [FRAME_BITS-1:0]      frame_cnt;  // sof pulses, wraps
    logic [FRAME_BITS-1:0]      frame_snap; // frame count at request
    logic [SEQ_BITS-1:0]        seq;        // sequence from the request

    assign wr_late   = cmd_valid && (cmd.addr == late_addr);
    assign wr_status = cmd_valid && (cmd.addr == status_addr);

    // late register
    always_ff @(posedge mclk) begin
        if (rst) begin
            late <= SENS_SYNC_LBITS'(SENS_SYNC_LATE_DFLT);
        end else if (wr_late) begin
            late <= cmd.data[SENS_SYNC_LBITS-1:0];
        end
    end

    // frame counter
    always_ff @(posedge mclk) begin
        if (rst) begin
            frame_cnt <= '0;
        end else if (sync.sof) begin
            frame_cnt <= frame_cnt + 1'b1;
        end
    end

    // request flag, a new write wins over start
    always_ff @(posedge mclk) begin
        if (rst) begin
            status_rq <= 1'b0;
        end else if (wr_status) begin
            status_rq <= 1'b1;
        end else if (start) begin
            status_rq <= 1'b0;      // drop the cycle after start
        end
    end

    // seq and frame snapshot, a pending request is overwritten
    always_ff @(posedge mclk) begin
        if (wr_status) begin
            seq        <= cmd.data[SEQ_BITS-1:0];
            frame_snap <= frame_cnt;
        end
    end

    // packet bytes
    assign status_pkt.addr = status_reg;
    assign status_pkt.st0  = {seq, frame_snap[1:0]};
    assign status_pkt.st1  = frame_snap[9:2];
    assign status_pkt.st2  = frame_snap[17:10];

    late_line_timer i_late_line_timer (
        .mclk     (mclk),
        .rst      (rst),
        .sync     (sync),
        .late     (late),
        .sof_late (sof_late)
    );

endmodule

/* design/status_router_fsm.sv */
// status_router_fsm: round-robin merge of the channel status packets onto one byte stream
`timescale 1ns/1ps

module status_router_fsm (
    input  logic                                   mclk,
    input  logic                                   rst,
    input  sensor_pkg::status_pkt_t                chn_pkt [sensor_pkg::NUM_SENSORS],
    input  logic [sensor_pkg::NUM_SENSORS-1:0]     chn_rq,     // per-channel request
    output logic [sensor_pkg::NUM_SENSORS-1:0]     chn_start,  // one cycle, packet taken
    output logic [7:0]                             status_ad,  // addr, then st0..st2
    output logic                                   status_rq,
    input  logic                                   status_start
);
    import sensor_pkg::*;

    typedef enum logic [1:0] {
        st_idle,   // wait for a channel request
        st_req,    // addr out, wait for status_start
        st_send    // st0, st1, st2
    } state_t;

    state_t              state;
    status_pkt_t         pkt;       // packet being sent
    logic [1:0]          byte_idx;  // data byte in st_send
    logic [CHN_BITS-1:0] last_chn;  // last served channel
    logic [CHN_BITS-1:0] cand;      // search candidate
    logic [CHN_BITS-1:0] pick;      // next channel to serve
    logic                pick_vld;

    // search from last_chn+1 around, nearest request wins
    always_comb begin
        pick_vld = 1'b0;
        pick     = last_chn;
        cand     = last_chn;
        for (int i = NUM_SENSORS; i >= 1; i--) begin
            cand = CHN_BITS'((int'(last_chn) + i) % NUM_SENSORS);
            if (chn_rq[cand]) begin
                pick_vld = 1'b1;
                pick     = cand;
            end
        end
    end

    always_ff @(posedge mclk) begin
        if (rst) begin
            state     <= st_idle;
            chn_start <= '0;
            byte_idx  <= '0;
            last_chn  <= CHN_BITS'(NUM_SENSORS - 1);  // first search starts at channel 0
        end else begin
            chn_start <= '0;
            case (state)
                st_idle: begin
                    if (pick_vld) begin
                        chn_start[pick] <= 1'b1;  // channel drops its request next cycle
                        last_chn        <= pick;
                        state           <= st_req;
                    end
                end
                st_req: begin
                    if (status_start) begin   // held here while downstream is busy
                        byte_idx <= '0;
                        state    <= st_send;
                    end
                end
                st_send: begin
                    byte_idx <= byte_idx + 1'b1;
                    if (byte_idx == 2'(STATUS_BYTES - 2)) begin
                        state <= st_idle;     // st2 out
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // take the packet with the start pulse
    always_ff @(posedge mclk) begin
        if (state == st_idle && pick_vld) begin
            pkt <= chn_pkt[pick];
        end
    end

    assign status_rq = (state == st_req);

    always_comb begin
        case (state)
            st_req:  status_ad = pkt.addr;
            st_send: begin
                case (byte_idx)
                    2'd0:    status_ad = pkt.st0;
                    2'd1:    status_ad = pkt.st1;
                    default: status_ad = pkt.st2;
                endcase
            end
            default: status_ad = 8'h00;
        endcase
    end

endmodule

/* design/sensor_ctrl_top.sv */
// sensor_ctrl_top: command port, four frame sync channels and the status router on mclk
`timescale 1ns/1ps

module sensor_ctrl_top (
    input  logic                               mclk,
    input  logic                               rst,
    input  logic [7:0]                         cmd_ad_in,   // byte-serial command
    input  logic                               cmd_stb_in,  // high with AL
    input  sensor_pkg::sync_in_t               sync_in [sensor_pkg::NUM_SENSORS],
    output logic [sensor_pkg::NUM_SENSORS-1:0] sof_late,    // delayed sof per channel
    output logic [7:0]                         status_ad,
    output logic                               status_rq,
    input  logic                               status_start
);
    import sensor_pkg::*;

    logic [7:0]             cmd_ad;     // registered command byte
    logic                   cmd_stb;    // registered strobe
    cmd_t                   cmd;        // assembled write
    logic                   cmd_valid;
    status_pkt_t            chn_pkt [NUM_SENSORS];
    logic [NUM_SENSORS-1:0] chn_rq;
    logic [NUM_SENSORS-1:0] chn_start;

    // input register stage
    always_ff @(posedge mclk) begin
        cmd_ad <= cmd_ad_in;
    end

    always_ff @(posedge mclk) begin
        if (rst) begin
            cmd_stb <= 1'b0;
        end else begin
            cmd_stb <= cmd_stb_in;
        end
    end

    cmd_deser i_cmd_deser (
        .mclk      (mclk),
        .rst       (rst),
        .cmd_ad    (cmd_ad),
        .cmd_stb   (cmd_stb),
        .cmd       (cmd),
        .cmd_valid (cmd_valid)
    );

    // channels share the write, each decodes its own addresses
    for (genvar g = 0; g < NUM_SENSORS; g++) begin : g_chn
        sync_chn #(
            .chn (g)
        ) i_sync_chn (
            .mclk       (mclk),
            .rst        (rst),
            .cmd        (cmd),
            .cmd_valid  (cmd_valid),
            .sync       (sync_in[g]),
            .sof_late   (sof_late[g]),
            .status_pkt (chn_pkt[g]),
            .status_rq  (chn_rq[g]),
            .start      (chn_start[g])
        );
    end

    status_router_fsm i_status_router_fsm (
        .mclk         (mclk),
        .rst          (rst),
        .chn_pkt      (chn_pkt),
        .chn_rq       (chn_rq),
        .chn_start    (chn_start),
        .status_ad    (status_ad),
        .status_rq    (status_rq),
        .status_start (status_start)
    );

endmodule

/* dv/tb_sensor_ctrl.sv */
// tb_sensor_ctrl drives random frame timing and commands and checks sof_late and status packets
`timescale 1ns/1ps

module tb_sensor_ctrl;
    import sensor_pkg::*;

    localparam int MAX_LINES   = 22;                       // late up to 20 plus two lines
    localparam int FRAME_CYC   = 10 + MAX_LINES * 5;       // sof, gaps up to 3, pulse, tail
    localparam int N_FRAMES    = 32;                       // frames over the whole run
    localparam int CMD_CYC     = 12;                       // six bytes plus settle
    localparam int N_CMDS      = 30;
    localparam int PKT_CYC     = 40;                       // wait, hold and four bytes
    localparam int N_PKTS      = 10;
    localparam int CYCLE_LIMIT = 2 * (20 + N_FRAMES * FRAME_CYC + N_CMDS * CMD_CYC
                                      + N_PKTS * PKT_CYC);

    logic                   mclk = 1'b0;
    logic                   rst;
    logic [7:0]             cmd_ad_in;
    logic                   cmd_stb_in;
    sync_in_t               sync_in [NUM_SENSORS];
    logic [NUM_SENSORS-1:0] sof_late;
    logic [7:0]             status_ad;
    logic                   status_rq;
    logic                   status_start;

    // model state
    int unsigned     m_late  [NUM_SENSORS];  // written by stimulus only
    int unsigned     m_frame [NUM_SENSORS];  // sof count mod 2**FRAME_BITS
    logic            m_pend  [NUM_SENSORS];  // sof waiting for its late pulse
    int unsigned     m_cnt   [NUM_SENSORS];  // line_end since sof
    logic            m_exp   [NUM_SENSORS];  // sof_late expected now
    logic [31:0]     exp_q [$];              // packets in expected order
    int unsigned     rd_idx;                 // packets received
    logic            hold_rd;                // reader holds off status_start
    string           cur_test = "reset";
    logic [31:0]     rng_main = 32'd27701;
    logic [31:0]     rng_rd   = 32'd27701;
    int unsigned     err_late = 0;
    int unsigned     err_stat = 0;
    int unsigned     err_main = 0;
    int unsigned     cycle_cnt = 0;

    always #50 mclk = ~mclk;  // 100 ns

    sensor_ctrl_top i_sensor_ctrl_top (
        .mclk         (mclk),
        .rst          (rst),
        .cmd_ad_in    (cmd_ad_in),
        .cmd_stb_in   (cmd_stb_in),
        .sync_in      (sync_in),
        .sof_late     (sof_late),
        .status_ad    (status_ad),
        .status_rq    (status_rq),
        .status_start (status_start)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic int unsigned rand_below(input logic [31:0] s, input int unsigned n);
        return (s >> 16) % n;  // take the upper state bits
    endfunction

    // addr then {seq, frame[1:0]} then frame[9:2] then frame[17:10]
    function automatic logic [31:0] make_pkt(input int c, input int unsigned seq,
                                              input int unsigned frame);
        logic [7:0]  a;
        logic [17:0] f;
        logic [5:0]  s;
        a = STATUS_REG_BASE + STATUS_REG_INC * 8'(c);
        f = 18'(frame);
        s = 6'(seq);
        return {a, s, f[1:0], f[9:2], f[17:10]};
    endfunction

    function automatic logic [15:0] chn_base(input int c);
        return SENSOR_GROUP_ADDR + 16'(c) * SENSOR_BASE_INC;
    endfunction

    task automatic roll(input int unsigned n, output int unsigned v);
        rng_main = lcg_next(rng_main);
        v = rand_below(rng_main, n);
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge mclk);
    endtask

    // bytes AL AH D0..D3 and the write lands in the channel before return
    task automatic write_cmd(input logic [15:0] addr, input logic [31:0] data);
        logic [47:0] bytes;
        bytes = {data, addr};
        for (int i = 0; i < CMD_BYTES; i++) begin
            @(posedge mclk);
            cmd_stb_in <= (i == 0);
            cmd_ad_in  <= bytes[8*i +: 8];
        end
        @(posedge mclk);
        cmd_stb_in <= 1'b0;
        idle(3);
    endtask

    task automatic pulse(input int c, input logic sof, input logic eof, input logic le);
        @(posedge mclk);
        sync_in[c] <= '{sof: sof, eof: eof, line_end: le};
        @(posedge mclk);
        sync_in[c] <= '0;
    endtask

    // sof then nlines line_end pulses where eof takes the place of line eof_line
    task automatic run_frame(input int c, input int nlines, input int eof_line);
        int unsigned gap;
        pulse(c, 1'b1, 1'b0, 1'b0);
        for (int l = 0; l < nlines; l++) begin
            roll(4, gap);
            idle(gap);
            if (l == eof_line) begin
                pulse(c, 1'b0, 1'b1, 1'b0);
                break;
            end
            pulse(c, 1'b0, 1'b0, 1'b1);
        end
        idle(3);
    endtask

    task automatic wait_drain();
        while (rd_idx != exp_q.size()) @(posedge mclk);
        idle(3);  // router back to idle
    endtask

    // sof_late model compares first and then steps on each edge
    always @(posedge mclk) begin : late_model
        for (int c = 0; c < NUM_SENSORS; c++) begin
            if (rst) begin
                m_pend[c]  = 1'b0;
                m_cnt[c]   = 0;
                m_exp[c]   = 1'b0;
                m_frame[c] = 0;
            end else begin
                if (sof_late[c] !== m_exp[c]) begin
                    err_late++;
                    $display("Error %s: sof_late[%0d] expected %0b actual %0b",
                             cur_test, c, m_exp[c], sof_late[c]);
                end
                m_exp[c] = 1'b0;
                if (sync_in[c].sof) begin
                    m_frame[c] = (m_frame[c] + 1) % (1 << FRAME_BITS);
                    m_cnt[c]   = 0;
                    m_pend[c]  = (m_late[c] != 0);
                    m_exp[c]   = (m_late[c] == 0);     // zero delay
                end else if (m_pend[c]) begin
                    if (sync_in[c].line_end) m_cnt[c]++;
                    if (sync_in[c].eof || m_cnt[c] == m_late[c]) begin
                        m_exp[c]  = 1'b1;              // early eof or last line
                        m_pend[c] = 1'b0;
                    end
                end
            end
        end
    end

    // status reader waits a random time and then collects four bytes
    initial begin : status_reader
        logic [7:0]  addr_b;
        logic [7:0]  d [3];
        logic [31:0] act;
        int unsigned wait_n;
        status_start <= 1'b0;
        rd_idx = 0;
        forever begin
            @(posedge mclk);
            if (!rst && status_rq === 1'b1) begin
                addr_b = status_ad;
                rng_rd = lcg_next(rng_rd);
                wait_n = rand_below(rng_rd, 6);
                while (hold_rd || wait_n > 0) begin
                    if (!hold_rd) wait_n--;
                    @(posedge mclk);
                    if (status_rq !== 1'b1) begin
                        err_stat++;
                        $display("status_rq dropped while status_start was held off");
                    end
                    if (status_ad !== addr_b) begin
                        err_stat++;
                        $display("Error %s: held status_ad expected %h actual %h",
                                 cur_test, addr_b, status_ad);
                    end
                end
                status_start <= 1'b1;
                @(posedge mclk);
                status_start <= 1'b0;
                for (int i = 0; i < 3; i++) begin
                    @(posedge mclk);
                    d[i] = status_ad;
                    if (status_rq !== 1'b0) begin
                        err_stat++;
                        $display("Error %s: status_rq in data byte %0d expected 0 actual %b",
                                 cur_test, i, status_rq);
                    end
                end
                act = {addr_b, d[0], d[1], d[2]};
                if (rd_idx >= exp_q.size()) begin
                    err_stat++;
                    $display("status packet %h arrived with no request outstanding", act);
                end else if (act !== exp_q[rd_idx]) begin
                    err_stat++;
                    $display("Error %s: packet expected %h actual %h",
                             cur_test, exp_q[rd_idx], act);
                end
                rd_idx++;
            end
        end
    end

    always @(posedge mclk) begin : watchdog
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin : stimulus
        int unsigned v;
        int unsigned n;
        int unsigned seq;
        int          a;
        int          x;
        int          c2;
        int unsigned total;
        rst        <= 1'b1;
        cmd_ad_in  <= 8'h00;
        cmd_stb_in <= 1'b0;
        hold_rd    <= 1'b0;
        for (int c = 0; c < NUM_SENSORS; c++) begin
            sync_in[c] <= '0;
            m_late[c]  = SENS_SYNC_LATE_DFLT;
        end
        idle(10);
        rst <= 1'b0;
        idle(2);
        if (status_rq !== 1'b0) begin
            err_main++;
            $display("Error %s: status_rq expected 0 actual %b", cur_test, status_rq);
        end
        if (sof_late !== '0) begin
            err_main++;
            $display("Error %s: sof_late expected 0 actual %b", cur_test, sof_late);
        end

        cur_test = "default_delay";
        for (int c = 0; c < NUM_SENSORS; c++) run_frame(c, SENS_SYNC_LATE_DFLT + 2, -1);

        cur_test = "programmed_delay";
        roll(NUM_SENSORS, n);                          // this channel gets late 0
        for (int c = 0; c < NUM_SENSORS; c++) begin
            roll(21, v);
            if (c == int'(n)) v = 0;
            roll(65536, seq);
            write_cmd(chn_base(c) + SENS_SYNC_LATE_REL, {16'(seq), 16'(v)});
            m_late[c] = v;
            write_cmd(chn_base(c) + 16'h0006, 32'(seq));  // unused register
        end
        for (int c = 0; c < NUM_SENSORS; c++) run_frame(c, m_late[c] + 2, -1);
        for (int c = 0; c < NUM_SENSORS; c++) begin
            roll((m_late[c] > 1) ? m_late[c] - 1 : 1, v);  // eof before the last line
            run_frame(c, m_late[c] + 2, int'(v));
        end

        cur_test = "single_status";
        for (int c = 0; c < NUM_SENSORS; c++) begin
            roll(5, n);
            repeat (n + 1) begin
                pulse(c, 1'b1, 1'b0, 1'b0);
                idle(2);
            end
            roll(64, seq);
            write_cmd(chn_base(c) + SENS_SYNC_STATUS_REL, {26'(v), 6'(seq)});
            exp_q.push_back(make_pkt(c, seq, m_frame[c]));
            wait_drain();
        end

        cur_test = "simultaneous";
        roll(NUM_SENSORS, v);
        a = int'(v);
        hold_rd <= 1'b1;
        for (int k = 0; k < NUM_SENSORS; k++) begin
            c2 = (a + NUM_SENSORS - k) % NUM_SENSORS;  // a, then a+3, a+2, a+1
            roll(64, seq);
            write_cmd(chn_base(c2) + SENS_SYNC_STATUS_REL, 32'(seq));
            exp_q.insert(exp_q.size() - (k == 0 ? 0 : k - 1), make_pkt(c2, seq, m_frame[c2]));
        end
        idle(5);
        hold_rd <= 1'b0;
        wait_drain();

        cur_test = "replace_backpressure";
        roll(NUM_SENSORS, v);
        x = int'(v);
        roll(3, v);
        c2 = (x + 1 + int'(v)) % NUM_SENSORS;
        hold_rd <= 1'b1;
        roll(64, seq);
        write_cmd(chn_base(x) + SENS_SYNC_STATUS_REL, 32'(seq));
        exp_q.push_back(make_pkt(x, seq, m_frame[x]));
        roll(64, seq);
        write_cmd(chn_base(c2) + SENS_SYNC_STATUS_REL, 32'(seq));  // replaced below
        pulse(c2, 1'b1, 1'b0, 1'b0);
        idle(2);
        roll(64, seq);
        write_cmd(chn_base(c2) + SENS_SYNC_STATUS_REL, 32'(seq));
        exp_q.push_back(make_pkt(c2, seq, m_frame[c2]));
        idle(10);
        hold_rd <= 1'b0;
        wait_drain();
        idle(10);                                  // a duplicate packet would show here

        cur_test = "final";
        if (rd_idx != exp_q.size()) begin
            err_main++;
            $display("Error %s: status packet count expected %0d actual %0d",
                     cur_test, exp_q.size(), rd_idx);
        end
        total = err_late + err_stat + err_main;
        $display("Errors: sof_late %0d, status %0d, other %0d", err_late, err_stat, err_main);
        if (total == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* verilog.f */
design/sensor_pkg.sv
design/cmd_deser.sv
design/late_line_timer.sv
design/sync_chn.sv
design/status_router_fsm.sv
design/sensor_ctrl_top.sv
dv/tb_sensor_ctrl.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the sensor control testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing -f verilog.f --top-module tb_sensor_ctrl -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "^Simulation completed successfully$" sim.log; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1
